// File: verilog/clockDisplayPkg.sv
`default_nettype none

package clockDisplayPkg;

   //**********************************************************************
   // Basic types and screen geometry
   //**********************************************************************
   typedef logic [9:0]  pixelCoordT;       // Screen x or y
   typedef logic [18:0] romAddrT;          // Frame memory word address
   typedef logic [3:0]  bcdDigitT;         // 10..15 shown as 0

   localparam int unsigned screenWidth = 640;   // Also the memory row stride

   // Large time digits, boxes inclusive (63 x 106)
   localparam pixelCoordT bigDigitWidth    = 10'd62;
   localparam pixelCoordT bigDigitHeight   = 10'd105;
   localparam pixelCoordT bigDigitTop      = 10'd197;
   localparam pixelCoordT bigHoursTensX    = 10'd58;
   localparam pixelCoordT bigHoursUnitsX   = 10'd123;
   localparam pixelCoordT bigMinutesTensX  = 10'd260;
   localparam pixelCoordT bigMinutesUnitsX = 10'd324;
   localparam pixelCoordT bigSecondsTensX  = 10'd459;
   localparam pixelCoordT bigSecondsUnitsX = 10'd524;
   localparam pixelCoordT bigRowBase       = 10'd192;  // Glyph row = y - base

   // Memory column where each large glyph starts
   localparam pixelCoordT bigGlyphColumn [10] = '{
      10'd0, 10'd67, 10'd127, 10'd192, 10'd253,
      10'd320, 10'd383, 10'd450, 10'd511, 10'd576
   };

   // Small digits: week number and stopwatch
   localparam pixelCoordT smallDigitWidth  = 10'd8;
   localparam pixelCoordT smallDigitHeight = 10'd12;
   localparam pixelCoordT weekTop          = 10'd14;
   localparam pixelCoordT weekTensX        = 10'd358;
   localparam pixelCoordT weekUnitsX       = 10'd366;
   localparam pixelCoordT stopwatchTop     = 10'd418;
   localparam pixelCoordT stopwatchHoursX   = 10'd104;
   localparam pixelCoordT stopwatchMinutesX = 10'd128;
   localparam pixelCoordT stopwatchSecondsX = 10'd152;
   localparam pixelCoordT smallRowBase     = 10'd326;  // Small font rows in memory

   localparam pixelCoordT smallGlyphColumn [10] = '{
      10'd1, 10'd10, 10'd21, 10'd31, 10'd40,
      10'd51, 10'd60, 10'd71, 10'd80, 10'd90
   };

   // Stripe, panel and background bands
   localparam pixelCoordT stripeTop       = 10'd244;
   localparam pixelCoordT stripeBottom    = 10'd247;
   localparam pixelCoordT panelTop        = 10'd141;
   localparam pixelCoordT panelBottom     = 10'd348;
   localparam pixelCoordT panelRowBase    = 10'd29;
   localparam pixelCoordT bandTopEnd      = 10'd140;   // Green above the panel
   localparam pixelCoordT bandGreenMidEnd = 10'd351;
   localparam pixelCoordT bandBlackEnd    = 10'd353;
   localparam pixelCoordT bandGreenLowEnd = 10'd472;
   localparam pixelCoordT screenBottom    = 10'd480;   // White line ends here

   //**********************************************************************
   // Enums and pipeline structs
   //**********************************************************************
   typedef enum logic [2:0] {
      colorGreen = 3'd0,
      colorBlack = 3'd1,
      colorWhite = 3'd2
   } colorIdxT;

   typedef enum logic [2:0] {
      regionBand,
      regionBigDigit,
      regionSmallDigit,
      regionPanel,
      regionOffScreen
   } regionT;

   typedef struct packed {
      bcdDigitT hoursTens;
      bcdDigitT hoursUnits;
      bcdDigitT minutesTens;
      bcdDigitT minutesUnits;
      bcdDigitT secondsTens;
      bcdDigitT secondsUnits;
   } clockTimeT;

   typedef clockTimeT stopwatchTimeT;   // Same six-digit layout

   typedef struct packed {
      bcdDigitT tens;
      bcdDigitT units;
   } weekNumT;

   typedef struct packed {
      pixelCoordT pixelX;
      pixelCoordT pixelY;
   } pixelReqT;

   typedef struct packed {
      regionT     region;
      bcdDigitT   digit;        // Already forced into 0..9
      logic [5:0] glyphCol;
      pixelCoordT glyphRow;     // Memory row, panel rows included
      pixelCoordT pixelX;
      colorIdxT   bandColor;
   } decodedPixelT;

   typedef struct packed {
      regionT   region;
      romAddrT  addr;
      colorIdxT bandColor;
   } glyphFetchT;

   typedef struct packed {
      romAddrT  romAddr;
      colorIdxT colorIdx;
      logic     graphicsEn;     // 1 = memory, 0 = flat colour
      logic     pixelOn;
   } pixelOutT;

endpackage

`default_nettype wire

// File: verilog/pixelRegionDecode.sv
`timescale 1ns/100ps
`default_nettype none

module pixelRegionDecode (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          pixelValid,   // One pixel per strobe
   input  clockDisplayPkg::pixelReqT     pixel,
   input  clockDisplayPkg::clockTimeT    timeNow,
   input  clockDisplayPkg::stopwatchTimeT stopwatch,
   input  clockDisplayPkg::weekNumT      weekNum,
   output clockDisplayPkg::decodedPixelT decoded,
   output logic                          decodedValid
);

   import clockDisplayPkg::*;

   // Left edges in display order, matched to the digit arrays below
   localparam pixelCoordT bigLeft [6] = '{
      bigHoursTensX, bigHoursUnitsX, bigMinutesTensX,
      bigMinutesUnitsX, bigSecondsTensX, bigSecondsUnitsX
   };
   localparam pixelCoordT swLeft [6] = '{
      stopwatchHoursX,   stopwatchHoursX + smallDigitWidth,
      stopwatchMinutesX, stopwatchMinutesX + smallDigitWidth,
      stopwatchSecondsX, stopwatchSecondsX + smallDigitWidth
   };

   bcdDigitT     bigDigits [6];
   bcdDigitT     swDigits [6];
   logic         bigRowsHit, swRowsHit, weekRowsHit;
   logic         bigHit, swHit;
   bcdDigitT     bigSel, swSel;
   logic [5:0]   bigCol;
   pixelCoordT   px, py;
   decodedPixelT nextDec;

   function automatic logic inRange(pixelCoordT v, pixelCoordT lo, pixelCoordT hi);
      return (v >= lo) && (v <= hi);
   endfunction

   // Non-decimal codes print as zero
   function automatic bcdDigitT validDigit(bcdDigitT d);
      return (d > 4'd9) ? 4'd0 : d;
   endfunction

   assign px = pixel.pixelX;
   assign py = pixel.pixelY;

   assign bigDigits = '{timeNow.hoursTens, timeNow.hoursUnits, timeNow.minutesTens,
                        timeNow.minutesUnits, timeNow.secondsTens, timeNow.secondsUnits};
   assign swDigits  = '{stopwatch.hoursTens, stopwatch.hoursUnits, stopwatch.minutesTens,
                        stopwatch.minutesUnits, stopwatch.secondsTens, stopwatch.secondsUnits};

   assign bigRowsHit  = inRange(py, bigDigitTop, bigDigitTop + bigDigitHeight);
   assign weekRowsHit = inRange(py, weekTop, weekTop + smallDigitHeight);
   assign swRowsHit   = inRange(py, stopwatchTop, stopwatchTop + smallDigitHeight);

   //**********************************************************************
   // Digit box search
   //**********************************************************************
   always_comb begin
      bigHit = 1'b0;
      bigSel = '0;
      swHit  = 1'b0;
      swSel  = '0;
      for (int i = 0; i < 6; i++) begin
         if (bigRowsHit && inRange(px, bigLeft[i], bigLeft[i] + bigDigitWidth)) begin
            bigHit = 1'b1;              // Boxes never overlap
            bigSel = bigDigits[i];
         end
         if (swRowsHit && inRange(px, swLeft[i], swLeft[i] + smallDigitWidth - 10'd1)) begin
            swHit = 1'b1;               // Tens [X, X+7], units [X+8, X+15]
            swSel = swDigits[i];
         end
      end
   end

   // Centre the glyph in its screen third, wraps modulo 64
   always_comb begin
      if (px < 10'd212)      bigCol = px[5:0] + 6'd5;
      else if (px < 10'd412) bigCol = px[5:0] - 6'd4;
      else                   bigCol = px[5:0] - 6'd12;
   end

   //**********************************************************************
   // Region priority
   //**********************************************************************
   always_comb begin
      nextDec.region    = regionBand;
      nextDec.digit     = '0;
      nextDec.glyphCol  = '0;
      nextDec.glyphRow  = '0;
      nextDec.pixelX    = px;
      nextDec.bandColor = colorGreen;
      if (inRange(py, stripeTop, stripeBottom)) begin
         nextDec.bandColor = colorBlack;             // Stripe cuts through everything
      end else if (bigHit) begin
         nextDec.region   = regionBigDigit;
         nextDec.digit    = validDigit(bigSel);
         nextDec.glyphCol = bigCol;
         nextDec.glyphRow = py - bigRowBase;
      end else if (weekRowsHit && inRange(px, weekUnitsX, weekUnitsX + smallDigitWidth)) begin
         nextDec.region   = regionSmallDigit;        // Units win the shared column
         nextDec.digit    = validDigit(weekNum.units);
         nextDec.glyphCol = {3'b000, px[2:0]};
         nextDec.glyphRow = py - weekTop + smallRowBase;
      end else if (weekRowsHit && inRange(px, weekTensX, weekTensX + smallDigitWidth)) begin
         nextDec.region   = regionSmallDigit;
         nextDec.digit    = validDigit(weekNum.tens);
         nextDec.glyphCol = {3'b000, px[2:0]};
         nextDec.glyphRow = py - weekTop + smallRowBase;
      end else if (swHit) begin
         nextDec.region   = regionSmallDigit;
         nextDec.digit    = validDigit(swSel);
         nextDec.glyphCol = {3'b000, px[2:0]};
         nextDec.glyphRow = py - stopwatchTop + smallRowBase;
      end else if (py > screenBottom) begin
         nextDec.region = regionOffScreen;           // Below the visible area
      end else if (py <= bandTopEnd) begin
         nextDec.bandColor = colorGreen;
      end else if (inRange(py, panelTop, panelBottom)) begin
         nextDec.region   = regionPanel;             // Row carries y - 29
         nextDec.glyphRow = py - panelRowBase;
      end else if (py <= bandGreenMidEnd) begin
         nextDec.bandColor = colorGreen;
      end else if (py <= bandBlackEnd) begin
         nextDec.bandColor = colorBlack;
      end else if (py <= bandGreenLowEnd) begin
         nextDec.bandColor = colorGreen;
      end else begin
         nextDec.bandColor = colorWhite;             // Bottom line
      end
   end

   always_ff @(posedge clk) begin
      if (pixelValid) decoded <= nextDec;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) decodedValid <= 1'b0;
      else       decodedValid <= pixelValid;
   end

endmodule

`default_nettype wire

// File: verilog/glyphAddressGen.sv
`timescale 1ns/100ps
`default_nettype none

module glyphAddressGen (
   input  logic                          clk,
   input  logic                          rstN,
   input  clockDisplayPkg::decodedPixelT decoded,
   input  logic                          decodedValid,
   output clockDisplayPkg::glyphFetchT   fetch,
   output logic                          fetchValid
);

   import clockDisplayPkg::*;

   romAddrT colTerm;     // Column inside the memory row
   romAddrT rowTerm;     // Memory row before the stride
   romAddrT addrNext;

   //**********************************************************************
   // Column and row selection per region
   //**********************************************************************
   always_comb begin
      colTerm = '0;
      rowTerm = '0;
      case (decoded.region)
         regionBigDigit: begin
            colTerm = romAddrT'(decoded.glyphCol)
                    + romAddrT'(bigGlyphColumn[decoded.digit]);
            rowTerm = romAddrT'(decoded.glyphRow);
         end
         regionSmallDigit: begin
            colTerm = romAddrT'(decoded.glyphCol)
                    + romAddrT'(smallGlyphColumn[decoded.digit]);
            rowTerm = romAddrT'(decoded.glyphRow);
         end
         regionPanel: begin
            colTerm = romAddrT'(decoded.pixelX);     // Panel maps one to one
            rowTerm = romAddrT'(decoded.glyphRow);
         end
         default: begin
            colTerm = '0;                            // Flat colour, no fetch
            rowTerm = '0;
         end
      endcase
   end

   // Single multiply-add, row times stride
   assign addrNext = colTerm + rowTerm * romAddrT'(screenWidth);

   //**********************************************************************
   // Execute register
   //**********************************************************************
   always_ff @(posedge clk) begin
      if (decodedValid) begin
         fetch.region    <= decoded.region;
         fetch.addr      <= addrNext;
         fetch.bandColor <= decoded.bandColor;     // Rides along for the result stage
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         fetchValid <= 1'b0;
      end else begin
         fetchValid <= decodedValid;
      end
   end

endmodule

`default_nettype wire

// File: verilog/pixelOutputStage.sv
`timescale 1ns/100ps
`default_nettype none

module pixelOutputStage (
   input  logic                        clk,
   input  logic                        rstN,
   input  clockDisplayPkg::glyphFetchT fetch,
   input  logic                        fetchValid,
   output clockDisplayPkg::pixelOutT   pixelOut,
   output logic                        outValid
);

   import clockDisplayPkg::*;

   pixelOutT outNext;

   // Region to output flags
   always_comb begin
      outNext.romAddr    = fetch.addr;
      outNext.colorIdx   = colorGreen;
      outNext.graphicsEn = 1'b1;          // Digits and panel read memory
      outNext.pixelOn    = 1'b1;
      case (fetch.region)
         regionBand: begin
            outNext.graphicsEn = 1'b0;
            outNext.colorIdx   = fetch.bandColor;
         end
         regionOffScreen: begin
            outNext.romAddr    = '0;      // Blank below the screen
            outNext.graphicsEn = 1'b0;
            outNext.pixelOn    = 1'b0;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pixelOut <= '0;
         outValid <= 1'b0;
      end else begin
         outValid <= fetchValid;
         if (fetchValid) pixelOut <= outNext;   // Holds between strobes
      end
   end

endmodule

`default_nettype wire

// File: verilog/clockDisplayRenderer.sv
`timescale 1ns/100ps
`default_nettype none

module clockDisplayRenderer (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           pixelValid,
   input  clockDisplayPkg::pixelReqT      pixel,
   input  clockDisplayPkg::clockTimeT     timeNow,
   input  clockDisplayPkg::stopwatchTimeT stopwatch,
   input  clockDisplayPkg::weekNumT       weekNum,
   output clockDisplayPkg::pixelOutT      pixelOut,
   output logic                           outValid
);

   import clockDisplayPkg::*;

   //**********************************************************************
   // Three stage pipeline, fixed latency of 3
   //**********************************************************************
   decodedPixelT decoded;        // Decode to execute
   logic         decodedValid;
   glyphFetchT   fetch;          // Execute to result
   logic         fetchValid;

   // Region and digit selection
   pixelRegionDecode i_pixelRegionDecode (
      .clk          (clk),
      .rstN         (rstN),
      .pixelValid   (pixelValid),
      .pixel        (pixel),
      .timeNow      (timeNow),
      .stopwatch    (stopwatch),
      .weekNum      (weekNum),
      .decoded      (decoded),
      .decodedValid (decodedValid)
   );

   // Frame memory address
   glyphAddressGen i_glyphAddressGen (
      .clk          (clk),
      .rstN         (rstN),
      .decoded      (decoded),
      .decodedValid (decodedValid),
      .fetch        (fetch),
      .fetchValid   (fetchValid)
   );

   // Output flags and registers
   pixelOutputStage i_pixelOutputStage (
      .clk        (clk),
      .rstN       (rstN),
      .fetch      (fetch),
      .fetchValid (fetchValid),
      .pixelOut   (pixelOut),
      .outValid   (outValid)
   );

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
   output logic clk
);

   // Free running testbench clock, 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;    // First rising edge at 20 ns
   end

endmodule

`default_nettype wire

// File: verification/clockDisplayTb.sv
`timescale 1ns/100ps
`default_nettype none

module clockDisplayTb;

   import clockDisplayPkg::*;

   typedef struct packed {
      pixelReqT      pixel;
      clockTimeT     timeNow;
      stopwatchTimeT stopwatch;
      weekNumT       weekNum;
      pixelOutT      expected;     // Filled by the reference model
   } stimEntryT;

   typedef struct packed {
      pixelOutT value;
      int       dueEdge;           // Rising edge count when the result must show
      int       index;             // Row of the stimulus table
   } pendingT;

   // Screen layout numbers used by the reference model
   localparam int bigGlyphTab [10]   = '{0, 67, 127, 192, 253, 320, 383, 450, 511, 576};
   localparam int smallGlyphTab [10] = '{1, 10, 21, 31, 40, 51, 60, 71, 80, 90};
   localparam int bigLeftTab [6]     = '{58, 123, 260, 324, 459, 524};
   localparam int bandRows [14]      = '{0, 140, 141, 348, 349, 351, 352, 353, 354,
                                         472, 473, 480, 481, 1023};

   logic          clk;
   logic          rstN;
   logic          pixelValid;
   pixelReqT      pixel;
   clockTimeT     timeNow;
   stopwatchTimeT stopwatch;
   weekNumT       weekNum;
   pixelOutT      pixelOut;
   logic          outValid;

   stimEntryT stimTable [$];
   pendingT   expectQ [$];        // Pixels in flight with the oldest first
   int        edgeCount;          // Rising edges seen so far
   int        checkedCount;
   bit        tableReady;

   clockGen i_clockGen (
      .clk (clk)
   );

   clockDisplayRenderer i_clockDisplayRenderer (
      .clk        (clk),
      .rstN       (rstN),
      .pixelValid (pixelValid),
      .pixel      (pixel),
      .timeNow    (timeNow),
      .stopwatch  (stopwatch),
      .weekNum    (weekNum),
      .pixelOut   (pixelOut),
      .outValid   (outValid)
   );

   always @(posedge clk) edgeCount = edgeCount + 1;

   task automatic failRun(string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic checkValue(string what, int actual, int expected);
      if (actual != expected) begin
         failRun($sformatf("CHECK FAILED at time %0t: %s, expected %0d, got %0d",
                           $time, what, expected, actual));
      end
   endtask

   //**********************************************************************
   // Reference model of one pixel
   //**********************************************************************
   function automatic pixelOutT expectPixel(stimEntryT e);
      pixelOutT res;
      bcdDigitT bigD [6];
      bcdDigitT swD [6];
      bcdDigitT d;
      int       x;
      int       y;
      int       sx;
      int       off;
      int       addr;
      bit       bigHit;
      bit       smallHit;
      x        = int'(e.pixel.pixelX);
      y        = int'(e.pixel.pixelY);
      bigD     = '{e.timeNow.hoursTens, e.timeNow.hoursUnits, e.timeNow.minutesTens,
                   e.timeNow.minutesUnits, e.timeNow.secondsTens, e.timeNow.secondsUnits};
      swD      = '{e.stopwatch.hoursTens, e.stopwatch.hoursUnits, e.stopwatch.minutesTens,
                   e.stopwatch.minutesUnits, e.stopwatch.secondsTens, e.stopwatch.secondsUnits};
      bigHit   = 1'b0;
      smallHit = 1'b0;
      d        = '0;
      addr     = 0;
      for (int i = 0; i < 6; i++) begin
         sx = 104 + 24 * (i / 2) + 8 * (i % 2);      // Stopwatch tens then units
         if (y >= 197 && y <= 302 && x >= bigLeftTab[i] && x <= bigLeftTab[i] + 62) begin
            bigHit = 1'b1;
            d      = bigD[i];
         end
         if (y >= 418 && y <= 430 && x >= sx && x <= sx + 7) begin
            smallHit = 1'b1;
            d        = swD[i];
            addr     = (y - 418 + 326) * 640 + x % 8;
         end
      end
      if (!bigHit && y >= 14 && y <= 26 && x >= 358 && x <= 374) begin
         smallHit = 1'b1;
         d        = (x >= 366) ? e.weekNum.units : e.weekNum.tens;   // 366 shows units
         addr     = (y - 14 + 326) * 640 + x % 8;
      end
      if (d > 4'd9) d = 4'd0;                        // Non-decimal reads as zero
      off          = (x < 212) ? 5 : ((x < 412) ? -4 : -12);
      res          = '0;
      res.pixelOn  = 1'b1;
      res.colorIdx = colorGreen;
      if (y >= 244 && y <= 247) begin
         res.colorIdx = colorBlack;                  // Stripe beats the digits
      end else if (bigHit) begin
         res.graphicsEn = 1'b1;
         res.romAddr    = romAddrT'((y - 192) * 640 + ((x + off) & 63) + bigGlyphTab[d]);
      end else if (smallHit) begin
         res.graphicsEn = 1'b1;
         res.romAddr    = romAddrT'(addr + smallGlyphTab[d]);
      end else if (y > 480) begin
         res.pixelOn = 1'b0;                         // Below the screen
      end else if (y >= 141 && y <= 348) begin
         res.graphicsEn = 1'b1;                      // Panel straight from memory
         res.romAddr    = romAddrT'(x + (y - 29) * 640);
      end else if (y == 352 || y == 353) begin
         res.colorIdx = colorBlack;
      end else if (y >= 473) begin
         res.colorIdx = colorWhite;
      end
      return res;
   endfunction

   function automatic void addEntry(int x, int y);
      stimEntryT e;
      e.pixel.pixelX = pixelCoordT'(x);
      e.pixel.pixelY = pixelCoordT'(y);
      e.timeNow      = 24'($urandom);                // Codes 10..15 included
      e.stopwatch    = 24'($urandom);
      e.weekNum      = 8'($urandom);
      e.expected     = expectPixel(e);
      stimTable.push_back(e);
   endfunction

   // Box edges, boundary columns, band rows, then random points
   function automatic void buildTable();
      for (int i = 0; i < 6; i++) begin
         addEntry(bigLeftTab[i], 197);               // Top left corner
         addEntry(bigLeftTab[i] + 62, 302);          // Bottom right corner
         addEntry(bigLeftTab[i] + 31, 243);
         addEntry(bigLeftTab[i] + 31, 248);
         addEntry(bigLeftTab[i] + 5, 244);           // Stripe rows
         addEntry(bigLeftTab[i] + 57, 247);
         addEntry(bigLeftTab[i] - 1, 250);           // Panel just beside the box
         addEntry(bigLeftTab[i] + 63, 250);
         addEntry(bigLeftTab[i] + 31, 196);          // Rows just above and below
         addEntry(bigLeftTab[i] + 31, 303);
      end
      for (int x = 356; x <= 376; x++) begin
         addEntry(x, 13 + x % 15);                   // Week rows 13..27
      end
      for (int x = 102; x <= 170; x++) begin
         addEntry(x, 417 + x % 15);                  // Stopwatch rows 417..431
      end
      for (int f = 0; f < 3; f++) begin
         addEntry(111 + 24 * f, 424);                // Stopwatch tens meet units here
         addEntry(112 + 24 * f, 424);
      end
      addEntry(0, 141);
      addEntry(639, 348);
      addEntry(400, 150);
      for (int i = 0; i < 14; i++) begin
         addEntry(5 + 45 * i, bandRows[i]);
      end
      for (int i = 0; i < 24; i++) begin
         addEntry(int'($urandom % 640), int'($urandom % 512));
      end
   endfunction

   //**********************************************************************
   // Output monitor at the falling edge where the DUT outputs are stable
   //**********************************************************************
   always @(negedge clk) begin : monitorOutputs
      pendingT pend;
      string   tag;
      if (!rstN) begin
         checkValue("outValid during reset", int'(outValid), 0);
         checkValue("pixelOn during reset", int'(pixelOut.pixelOn), 0);
      end else if (outValid) begin
         if (expectQ.size() == 0) begin
            failRun("outValid went high with no pixel in flight");
         end else begin
            pend = expectQ.pop_front();
            tag  = $sformatf("pixel %0d at (%0d,%0d)", pend.index,
                             stimTable[pend.index].pixel.pixelX,
                             stimTable[pend.index].pixel.pixelY);
            checkValue({tag, " arrival edge"}, edgeCount, pend.dueEdge);
            checkValue({tag, " romAddr"}, int'(pixelOut.romAddr), int'(pend.value.romAddr));
            checkValue({tag, " colorIdx"}, int'(pixelOut.colorIdx), int'(pend.value.colorIdx));
            checkValue({tag, " graphicsEn"}, int'(pixelOut.graphicsEn),
                       int'(pend.value.graphicsEn));
            checkValue({tag, " pixelOn"}, int'(pixelOut.pixelOn), int'(pend.value.pixelOn));
            checkedCount = checkedCount + 1;
         end
      end else if (expectQ.size() > 0 && edgeCount >= expectQ[0].dueEdge) begin
         failRun($sformatf("No output for pixel %0d three cycles after its input",
                           expectQ[0].index));
      end
   end

   // Watchdog sized from the table length at 40 ns per cycle
   initial begin
      wait (tableReady);
      #((stimTable.size() + 20) * 40);
      failRun("Watchdog timeout, the pixel stream never finished");
   end

   //**********************************************************************
   // Main sequence
   //**********************************************************************
   initial begin
      pendingT pend;
      rstN       = 1'b0;
      pixelValid = 1'b0;
      pixel      = '0;
      timeNow    = '0;
      stopwatch  = '0;
      weekNum    = '0;
      void'($urandom(32'he755b230));                 // One seed for the whole run
      buildTable();
      tableReady = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      rstN = 1'b1;
      @(negedge clk);
      checkValue("outValid after reset", int'(outValid), 0);
      checkValue("pixelOn after reset", int'(pixelOut.pixelOn), 0);
      for (int i = 0; i < stimTable.size(); i++) begin
         @(posedge clk);
         #2;
         if (i == stimTable.size() / 2) begin
            pixelValid = 1'b0;                       // One idle cycle mid stream
            @(posedge clk);
            #2;
         end
         pixelValid   = 1'b1;
         pixel        = stimTable[i].pixel;
         timeNow      = stimTable[i].timeNow;
         stopwatch    = stimTable[i].stopwatch;
         weekNum      = stimTable[i].weekNum;
         pend.value   = stimTable[i].expected;
         pend.dueEdge = edgeCount + 3;               // Three register stages
         pend.index   = i;
         expectQ.push_back(pend);
      end
      @(posedge clk);
      #2;
      pixelValid = 1'b0;
      repeat (6) @(negedge clk);                     // Drain the pipeline
      if (expectQ.size() == 0 && checkedCount == stimTable.size()) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         failRun($sformatf("Only %0d of %0d pixel results arrived",
                           checkedCount, stimTable.size()));
      end
   end

endmodule

`default_nettype wire

// File: all.f
verilog/clockDisplayPkg.sv
verilog/pixelRegionDecode.sv
verilog/glyphAddressGen.sv
verilog/pixelOutputStage.sv
verilog/clockDisplayRenderer.sv
verification/clockGen.sv
verification/clockDisplayTb.sv

// File: Makefile
# Verilator build and run of the clock display renderer testbench
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 --Mdir $(OBJ_DIR)
TOP       = clockDisplayTb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
